// File: Makefile
# Verilator simulation of the pipelined FPU, run from the project root

sim:
	verilator --binary --timing --assert -j 0 --top-module fpu_tb -f sim.f
	./obj_dir/Vfpu_tb > sim.log 2>&1 || true
	cat sim.log
	if grep -q "test failed" sim.log; then exit 1; fi
	grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: sim.f
source/fpu_pkg.sv
source/fpu_ifs.sv
source/operand_aligner.sv
source/calculation_unit.sv
source/result_stage.sv
source/fpu_top.sv
tests/fpu_chk.sv
tests/fpu_tb.sv

// File: source/calculation_unit.sv
`timescale 1ns/1ps
/*
 * calculation unit, pipeline stage 2
 * adds, subtracts or multiplies the significands and hands a 2.46 value
 * to the result stage together with the pass-through fields
 */
module calculation_unit (
    input  logic        clk,
    input  logic        reset,
    align_if.dst        aligned,
    calc_if.src         calc
);

    logic [fpu_pkg::MANT_W+fpu_pkg::GRS_W:0]   addend_a;
    logic [fpu_pkg::MANT_W+fpu_pkg::GRS_W:0]   addend_b;
    logic [fpu_pkg::MANT_W+fpu_pkg::GRS_W:0]   sum;
    logic [fpu_pkg::MANT_W-1:0]                multiplier_b;
    logic [fpu_pkg::PROD_W-1:0]                fraction;

    always_comb begin
        // one spare bit on top takes the carry of an addition
        addend_a     = {1'b0, aligned.fraction_a, {fpu_pkg::GRS_W{1'b0}}};
        addend_b     = {1'b0, aligned.fraction_b};
        multiplier_b = aligned.fraction_b[fpu_pkg::MANT_W+fpu_pkg::GRS_W-1:fpu_pkg::GRS_W];

        if (aligned.kind == fpu_pkg::kind_sub)
            sum = addend_a - addend_b;
        else
            sum = addend_a + addend_b;

        if (aligned.kind == fpu_pkg::kind_mul)
            fraction = aligned.fraction_a * multiplier_b;
        else
            fraction = {sum, {(fpu_pkg::PROD_W - fpu_pkg::MANT_W - fpu_pkg::GRS_W - 1){1'b0}}};
    end

    always_ff @(posedge clk) begin
        if (reset)
            calc.valid <= 1'b0;
        else
            calc.valid <= aligned.valid;
    end

    always_ff @(posedge clk) begin
        calc.round_mode  <= aligned.round_mode;
        calc.result_sign <= aligned.result_sign;
        calc.exponent    <= aligned.exponent;
        calc.fraction    <= fraction;
        calc.special     <= aligned.special;
    end

endmodule

// File: source/fpu_ifs.sv
`timescale 1ns/1ps
/*
 * stage boundary interfaces
 * align_if carries decoded and aligned operands from stage 1 to stage 2,
 * calc_if carries the raw significand result from stage 2 to stage 3
 */
interface align_if;
    logic                                    valid;
    fpu_pkg::calc_kind_t                     kind;
    fpu_pkg::round_mode_t                    round_mode;
    logic                                    result_sign;
    logic signed [fpu_pkg::WORK_EXP_W-1:0]   exponent;
    // 1.23 format with the hidden bit on top
    logic [fpu_pkg::MANT_W-1:0]              fraction_a;
    // 1.26 format, the lowest bit is sticky after alignment
    logic [fpu_pkg::MANT_W+fpu_pkg::GRS_W-1:0] fraction_b;
    fpu_pkg::special_t                       special;

    modport src (output valid, kind, round_mode, result_sign, exponent,
                 fraction_a, fraction_b, special);
    modport dst (input valid, kind, round_mode, result_sign, exponent,
                 fraction_a, fraction_b, special);
endinterface


interface calc_if;
    logic                                    valid;
    fpu_pkg::round_mode_t                    round_mode;
    logic                                    result_sign;
    logic signed [fpu_pkg::WORK_EXP_W-1:0]   exponent;
    // 2.46 format, two integer bits above the binary point
    logic [fpu_pkg::PROD_W-1:0]              fraction;
    fpu_pkg::special_t                       special;

    modport src (output valid, round_mode, result_sign, exponent, fraction, special);
    modport dst (input valid, round_mode, result_sign, exponent, fraction, special);
endinterface

// File: source/fpu_pkg.sv
/*
 * fpu package
 * field widths, reserved encodings and the enums shared by the three
 * pipeline stages of the binary32 floating-point unit
 */
package fpu_pkg;

    localparam int EXP_W      = 8;
    localparam int FRAC_W     = 23;
    localparam int MANT_W     = 24;
    localparam int WORK_EXP_W = 10;
    localparam int GRS_W      = 3;
    localparam int PROD_W     = 48;

    // working exponents are signed so underflow shows up as a negative value
    localparam logic signed [WORK_EXP_W-1:0] EXP_BIAS     = 127;
    localparam logic signed [WORK_EXP_W-1:0] EXP_ALL_ONES = 255;

    localparam logic [31:0] QNAN       = 32'h7fc0_0000;
    localparam logic [31:0] MAX_FINITE = 32'h7f7f_ffff;

    // bit 2 of the opcode selects round toward zero
    typedef enum logic [3:0] {
        op_add    = 4'd0,
        op_sub    = 4'd1,
        op_mul    = 4'd2,
        op_add_rz = 4'd4,
        op_sub_rz = 4'd5,
        op_mul_rz = 4'd6
    } fp_op_t;

    typedef enum logic [1:0] {
        kind_add,
        kind_sub,
        kind_mul
    } calc_kind_t;

    typedef enum logic {
        round_nearest_even,
        round_to_zero
    } round_mode_t;

    typedef enum logic [1:0] {
        special_none,
        special_zero,
        special_inf,
        special_nan
    } special_t;

endpackage

// File: source/fpu_top.sv
`timescale 1ns/1ps
/*
 * three-stage pipelined binary32 FPU
 * add, subtract and multiply with nearest-even or toward-zero rounding,
 * one operation per cycle, result two edges after start
 */
module fpu_top (
    input  logic             clk,
    input  logic             reset,
    input  fpu_pkg::fp_op_t  op,
    input  logic             start,
    input  logic [31:0]      operand_a,
    input  logic [31:0]      operand_b,
    output logic             valid,
    output logic [31:0]      result
);

    align_if align_bus ();
    calc_if  calc_bus ();

    operand_aligner operand_aligner (
        .clk       (clk),
        .reset     (reset),
        .op        (op),
        .start     (start),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .stage     (align_bus.src)
    );

    calculation_unit calculation_unit (
        .clk     (clk),
        .reset   (reset),
        .aligned (align_bus.dst),
        .calc    (calc_bus.src)
    );

    // last stage is combinational, so the result leaves with the stage 2 register
    result_stage result_stage (
        .calc   (calc_bus.dst),
        .result (result),
        .valid  (valid)
    );

endmodule

// File: source/operand_aligner.sv
`timescale 1ns/1ps
/*
 * operand aligner, pipeline stage 1
 * unpacks and classifies both operands, decodes the opcode, picks the
 * special result and aligns the smaller addend before registering it all
 */
module operand_aligner (
    input  logic                  clk,
    input  logic                  reset,
    input  fpu_pkg::fp_op_t       op,
    input  logic                  start,
    input  logic [31:0]           operand_a,
    input  logic [31:0]           operand_b,
    align_if.src                  stage
);

    logic                                       sign_a;
    logic                                       sign_b;
    logic [fpu_pkg::EXP_W-1:0]                  exp_a;
    logic [fpu_pkg::EXP_W-1:0]                  exp_b;
    logic [fpu_pkg::MANT_W-1:0]                 frac_a;
    logic [fpu_pkg::MANT_W-1:0]                 frac_b;
    logic                                       zero_a;
    logic                                       zero_b;
    logic                                       inf_a;
    logic                                       inf_b;
    logic                                       nan_a;
    logic                                       nan_b;
    logic                                       is_sub;
    logic                                       is_mul;
    logic                                       op_defined;
    fpu_pkg::round_mode_t                       round_mode;

    logic                                       a_larger;
    logic [fpu_pkg::EXP_W-1:0]                  exp_big;
    logic [fpu_pkg::EXP_W-1:0]                  exp_small;
    logic [fpu_pkg::MANT_W-1:0]                 frac_big;
    logic [fpu_pkg::MANT_W-1:0]                 frac_small;
    logic [fpu_pkg::EXP_W-1:0]                  shift;
    logic [4:0]                                 shift_clamped;
    logic [fpu_pkg::MANT_W+fpu_pkg::GRS_W-1:0]  shifted;
    logic [fpu_pkg::MANT_W+fpu_pkg::GRS_W-1:0]  shifted_out;
    logic [fpu_pkg::MANT_W+fpu_pkg::GRS_W-1:0]  aligned_b;

    fpu_pkg::calc_kind_t                        kind;
    fpu_pkg::special_t                          special;
    logic                                       result_sign;
    logic signed [fpu_pkg::WORK_EXP_W-1:0]      exponent;

    always_comb begin
        exp_a  = operand_a[fpu_pkg::FRAC_W +: fpu_pkg::EXP_W];
        exp_b  = operand_b[fpu_pkg::FRAC_W +: fpu_pkg::EXP_W];
        // a zero exponent covers subnormals too, both act as zero
        zero_a = (exp_a == '0);
        zero_b = (exp_b == '0);
        inf_a  = (&exp_a) && (operand_a[fpu_pkg::FRAC_W-1:0] == '0);
        inf_b  = (&exp_b) && (operand_b[fpu_pkg::FRAC_W-1:0] == '0);
        nan_a  = (&exp_a) && (operand_a[fpu_pkg::FRAC_W-1:0] != '0);
        nan_b  = (&exp_b) && (operand_b[fpu_pkg::FRAC_W-1:0] != '0);
        frac_a = zero_a ? '0 : {1'b1, operand_a[fpu_pkg::FRAC_W-1:0]};
        frac_b = zero_b ? '0 : {1'b1, operand_b[fpu_pkg::FRAC_W-1:0]};

        is_sub     = 1'b0;
        is_mul     = 1'b0;
        op_defined = 1'b1;
        round_mode = fpu_pkg::round_nearest_even;
        case (op)
            fpu_pkg::op_add:    op_defined = 1'b1;
            fpu_pkg::op_sub:    is_sub = 1'b1;
            fpu_pkg::op_mul:    is_mul = 1'b1;
            fpu_pkg::op_add_rz: round_mode = fpu_pkg::round_to_zero;
            fpu_pkg::op_sub_rz: begin
                is_sub     = 1'b1;
                round_mode = fpu_pkg::round_to_zero;
            end
            fpu_pkg::op_mul_rz: begin
                is_mul     = 1'b1;
                round_mode = fpu_pkg::round_to_zero;
            end
            default:            op_defined = 1'b0;
        endcase

        sign_a = operand_a[31];
        // subtraction is addition with b negated
        sign_b = operand_b[31] ^ is_sub;
    end

    // order by magnitude so the difference of significands is never negative
    always_comb begin
        a_larger   = {exp_a, frac_a[fpu_pkg::FRAC_W-1:0]} >= {exp_b, frac_b[fpu_pkg::FRAC_W-1:0]};
        exp_big    = a_larger ? exp_a : exp_b;
        exp_small  = a_larger ? exp_b : exp_a;
        frac_big   = a_larger ? frac_a : frac_b;
        frac_small = a_larger ? frac_b : frac_a;

        shift = exp_big - exp_small;
        if (shift > 8'(fpu_pkg::MANT_W + fpu_pkg::GRS_W))
            shift_clamped = 5'(fpu_pkg::MANT_W + fpu_pkg::GRS_W);
        else
            shift_clamped = shift[4:0];

        // the lower half catches every bit pushed out of the addend
        {shifted, shifted_out} = {frac_small, {fpu_pkg::GRS_W{1'b0}},
                                  {(fpu_pkg::MANT_W + fpu_pkg::GRS_W){1'b0}}} >> shift_clamped;
        aligned_b = {shifted[fpu_pkg::MANT_W+fpu_pkg::GRS_W-1:1],
                     shifted[0] | (|shifted_out)};
    end

    always_comb begin
        special = fpu_pkg::special_none;
        if (is_mul) begin
            kind        = fpu_pkg::kind_mul;
            result_sign = sign_a ^ sign_b;
            exponent    = $signed({2'b00, exp_a}) + $signed({2'b00, exp_b}) - fpu_pkg::EXP_BIAS;
            if (nan_a || nan_b || (inf_a && zero_b) || (zero_a && inf_b))
                special = fpu_pkg::special_nan;
            else if (inf_a || inf_b)
                special = fpu_pkg::special_inf;
            else if (zero_a || zero_b)
                special = fpu_pkg::special_zero;
        end else begin
            kind        = (sign_a == sign_b) ? fpu_pkg::kind_add : fpu_pkg::kind_sub;
            result_sign = a_larger ? sign_a : sign_b;
            exponent    = {2'b00, exp_big};
            if (nan_a || nan_b || (inf_a && inf_b && (sign_a != sign_b))) begin
                special = fpu_pkg::special_nan;
            end else if (inf_a) begin
                special     = fpu_pkg::special_inf;
                result_sign = sign_a;
            end else if (inf_b) begin
                special     = fpu_pkg::special_inf;
                result_sign = sign_b;
            end else if (zero_a && zero_b) begin
                // two zeros only stay negative when both are negative
                special     = fpu_pkg::special_zero;
                result_sign = sign_a & sign_b;
            end
        end
        if (!op_defined)
            special = fpu_pkg::special_nan;
    end

    always_ff @(posedge clk) begin
        if (reset)
            stage.valid <= 1'b0;
        else
            stage.valid <= start;
    end

    always_ff @(posedge clk) begin
        stage.kind        <= kind;
        stage.round_mode  <= round_mode;
        stage.result_sign <= result_sign;
        stage.exponent    <= exponent;
        stage.special     <= special;
        stage.fraction_a  <= is_mul ? frac_a : frac_big;
        stage.fraction_b  <= is_mul ? {frac_b, {fpu_pkg::GRS_W{1'b0}}} : aligned_b;
    end

endmodule

// File: source/result_stage.sv
`timescale 1ns/1ps
/*
 * result stage, pipeline stage 3
 * normalizes and rounds the computed significand, clamps overflow and
 * underflow and lets an early special result win
 */
module result_stage (
    calc_if.dst          calc,
    output logic [31:0]  result,
    output logic         valid
);

    logic [5:0]                              lead_zeros;
    logic signed [fpu_pkg::WORK_EXP_W-1:0]   lead_zeros_ext;
    logic [fpu_pkg::PROD_W-1:0]              normalized;
    logic signed [fpu_pkg::WORK_EXP_W-1:0]   norm_exp;
    logic signed [fpu_pkg::WORK_EXP_W-1:0]   final_exp;
    logic                                    guard;
    logic                                    round_bit;
    logic                                    sticky;
    logic                                    round_up;
    logic [fpu_pkg::MANT_W:0]                rounded;
    logic [fpu_pkg::FRAC_W-1:0]              mantissa;
    logic [31:0]                             computed;

    always_comb begin
        // the last hit is the highest set bit
        lead_zeros = '0;
        for (int i = 0; i < fpu_pkg::PROD_W; i++) begin
            if (calc.fraction[i])
                lead_zeros = 6'(fpu_pkg::PROD_W - 1 - i);
        end
        lead_zeros_ext = {{(fpu_pkg::WORK_EXP_W - 6){1'b0}}, lead_zeros};

        // hidden bit moves to the top, a leading one at bit 46 keeps the exponent
        normalized = calc.fraction << lead_zeros;
        norm_exp   = calc.exponent - lead_zeros_ext + 10'sd1;

        guard     = normalized[fpu_pkg::PROD_W-fpu_pkg::MANT_W-1];
        round_bit = normalized[fpu_pkg::PROD_W-fpu_pkg::MANT_W-2];
        sticky    = |normalized[fpu_pkg::PROD_W-fpu_pkg::MANT_W-3:0];
        round_up  = (calc.round_mode == fpu_pkg::round_nearest_even) && guard &&
                    (round_bit || sticky || normalized[fpu_pkg::PROD_W-fpu_pkg::MANT_W]);

        rounded = {1'b0, normalized[fpu_pkg::PROD_W-1 -: fpu_pkg::MANT_W]} +
                  {{fpu_pkg::MANT_W{1'b0}}, round_up};

        // a carry out of rounding leaves 1.000... one binade higher
        if (rounded[fpu_pkg::MANT_W]) begin
            mantissa  = rounded[fpu_pkg::FRAC_W:1];
            final_exp = norm_exp + 10'sd1;
        end else begin
            mantissa  = rounded[fpu_pkg::FRAC_W-1:0];
            final_exp = norm_exp;
        end
    end

    always_comb begin
        if (calc.fraction == '0) begin
            // exact cancellation is +0 in both rounding modes
            computed = '0;
        end else if (final_exp >= fpu_pkg::EXP_ALL_ONES) begin
            if (calc.round_mode == fpu_pkg::round_to_zero)
                computed = {calc.result_sign, fpu_pkg::MAX_FINITE[30:0]};
            else
                computed = {calc.result_sign, fpu_pkg::EXP_ALL_ONES[fpu_pkg::EXP_W-1:0],
                            {fpu_pkg::FRAC_W{1'b0}}};
        end else if (final_exp[fpu_pkg::WORK_EXP_W-1] || final_exp == '0) begin
            // would be subnormal, flush to zero keeping the sign
            computed = {calc.result_sign, 31'b0};
        end else begin
            computed = {calc.result_sign, final_exp[fpu_pkg::EXP_W-1:0], mantissa};
        end

        case (calc.special)
            fpu_pkg::special_zero: result = {calc.result_sign, 31'b0};
            fpu_pkg::special_inf:  result = {calc.result_sign,
                                             fpu_pkg::EXP_ALL_ONES[fpu_pkg::EXP_W-1:0],
                                             {fpu_pkg::FRAC_W{1'b0}}};
            fpu_pkg::special_nan:  result = fpu_pkg::QNAN;
            default:               result = computed;
        endcase

        valid = calc.valid;
    end

endmodule

// File: tests/fpu_chk.sv
`timescale 1ns/1ps
/*
 * port checker for the FPU top level, bound into fpu_top
 * watches the valid strobe against start and reset, and the result for unknowns
 */
module fpu_chk (
    input logic        clk,
    input logic        reset,
    input logic        start,
    input logic        valid,
    input logic [31:0] result
);

    // edges seen since reset was released, saturating at two
    logic [1:0] settle;

    // assertion failures seen so far, read by the testbench
    int unsigned failed_count = 0;

    always_ff @(posedge clk) begin
        if (reset)
            settle <= 2'd0;
        else if (settle != 2'd2)
            settle <= settle + 2'd1;
    end

    valid_low_around_reset: assert property (
        @(posedge clk) (reset || $past(reset)) |=> !valid
    ) else begin
        failed_count++;
        $error("valid was high during reset or on the cycle after it");
    end

    // the pipeline is two registers deep, so valid mirrors start two edges back
    valid_follows_start: assert property (
        @(posedge clk) (!reset && settle == 2'd2) |-> (valid == $past(start, 2))
    ) else begin
        failed_count++;
        $error("valid does not match start from two cycles earlier");
    end

    result_known: assert property (
        @(posedge clk) valid |-> !$isunknown(result)
    ) else begin
        failed_count++;
        $error("result has unknown bits while valid is high");
    end

endmodule

bind fpu_top fpu_chk port_checks (
    .clk    (clk),
    .reset  (reset),
    .start  (start),
    .valid  (valid),
    .result (result)
);

// File: tests/fpu_tb.sv
`timescale 1ns/1ps
/*
 * testbench for the pipelined binary32 FPU
 * issues file vectors with random idle gaps and checks results in issue order
 */
module fpu_tb;

    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 4;
    localparam int SEED           = 75067;
    localparam int NUM_VECTORS    = 29;
    localparam int TIMEOUT_CYCLES = 4 * NUM_VECTORS + 50;

    typedef struct packed {
        logic [31:0] opcode;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] expected;
    } fp_vector_t;

    logic            clk;
    logic            reset;
    fpu_pkg::fp_op_t op;
    logic            start;
    logic [31:0]     operand_a;
    logic [31:0]     operand_b;
    logic            valid;
    logic [31:0]     result;

    logic [31:0]     vector_mem [0:4*NUM_VECTORS-1];
    fp_vector_t      vectors [0:NUM_VECTORS-1];
    logic [31:0]     expected_q [$];
    int              index_q [$];
    int              cycle_count = 0;
    int unsigned     gap;

    fpu_top uut (
        .clk       (clk),
        .reset     (reset),
        .op        (op),
        .start     (start),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .valid     (valid),
        .result    (result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("MISMATCH at time %0t: %s gave %08h, expected %08h",
                     $time, what, actual, expected);
            $display("test failed");
            $fatal(1, "result check failed");
        end
    endtask

    // the run is bounded by cycles, whatever state the pipeline is in
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles with %0d results still missing",
                     cycle_count, expected_q.size());
            $display("test failed");
            $fatal(1, "simulation timed out");
        end
    end

    // results are compared mid-cycle where they are stable
    always @(negedge clk) begin
        if (uut.port_checks.failed_count != 0) begin
            $display("a bound assertion on the DUT ports failed");
            $display("test failed");
            $fatal(1, "assertion failure");
        end else if (valid === 1'b1) begin
            if (expected_q.size() == 0) begin
                $display("a result %08h came out with no operation in flight", result);
                $display("test failed");
                $fatal(1, "unexpected result");
            end else begin
                check_value(result, expected_q.pop_front(),
                            $sformatf("vector %0d", index_q.pop_front()));
            end
        end
    end

    initial begin
        void'($urandom(SEED));
        reset     = 1'b1;
        start     = 1'b0;
        op        = fpu_pkg::op_add;
        operand_a = '0;
        operand_b = '0;

        $readmemh("tests/fpu_vectors.txt", vector_mem);
        for (int i = 0; i < NUM_VECTORS; i++) begin
            vectors[i] = {vector_mem[4*i], vector_mem[4*i+1],
                          vector_mem[4*i+2], vector_mem[4*i+3]};
        end

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        for (int i = 0; i < NUM_VECTORS; i++) begin
            // zero gaps in a row give back-to-back issue
            gap = $urandom % 3;
            repeat (gap) begin
                @(posedge clk);
                start <= 1'b0;
            end
            @(posedge clk);
            start     <= 1'b1;
            op        <= fpu_pkg::fp_op_t'(vectors[i].opcode[3:0]);
            operand_a <= vectors[i].a;
            operand_b <= vectors[i].b;
            expected_q.push_back(vectors[i].expected);
            index_q.push_back(i);
        end
        @(posedge clk);
        start <= 1'b0;

        while (expected_q.size() != 0)
            @(posedge clk);
        // a few quiet cycles expose any extra valid
        repeat (3) @(posedge clk);
        @(negedge clk);

        if (uut.port_checks.failed_count == 0) begin
            $display("test passed");
            $finish;
        end else begin
            $display("%0d bound assertions on the DUT ports failed",
                     uut.port_checks.failed_count);
            $display("test failed");
            $fatal(1, "assertion failures");
        end
    end

endmodule

// File: tests/fpu_vectors.txt
// columns: opcode, operand a, operand b, expected result (all hex)
// opcodes: 0 add, 1 sub, 2 mul, 4 add_rz, 5 sub_rz, 6 mul_rz, others undefined
0 3f800000 40000000 40400000
1 3fc00000 3e800000 3fa00000
0 42c80000 3f000000 42c90000
1 40400000 42c80000 c2c20000
0 3f800000 33800000 3f800000
0 3f800001 33800000 3f800002
0 3f800000 33c00000 3f800001
4 3f800000 33c00000 3f800000
1 3f800000 33000000 3f800000
5 3f800000 33000000 3f7fffff
0 3fc00000 bfc00000 00000000
5 40000000 40000000 00000000
2 3fc00000 40000000 40400000
2 c0400000 3f000000 bfc00000
2 40400000 3f800001 40400002
6 40400000 3f800001 40400001
2 3f800001 3ffffffe 40000000
6 3f800001 3ffffffe 3fffffff
2 7f000000 40000000 7f800000
6 ff000000 40000000 ff7fffff
2 8d800000 0d800000 80000000
1 7f800000 7f800000 7fc00000
2 00000000 7f800000 7fc00000
0 7fa00000 3f800000 7fc00000
3 3f800000 40000000 7fc00000
0 00400000 3f800000 3f800000
0 80000001 80400000 80000000
0 00000000 80000000 00000000
0 ff800000 42c80000 ff800000
